//--- vlog.f
scrub_pkg.sv
scrub_ctl.sv
ddr_scrubber.sv
scrub_status.sv
cl_scrub_top.sv
tb_cl_scrub_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the scrubber testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
   -f vlog.f \
   --top-module tb_cl_scrub_top \
   --Mdir "$OBJ" -o tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build returned status $status"
   exit 1
fi

"./$OBJ/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation returned status $status"
   exit 1
fi

if grep -qx "test passed" "$LOG"; then
   exit 0
fi

echo "pass message not found in $LOG"
exit 1

//--- tb_cl_scrub_top.sv
// Scrubber top testbench

`timescale 1ns/1ps
`default_nettype none

module tb_cl_scrub_top
   import scrub_pkg::*;
();

   // bursts in one full scrub and the address of the last one
   localparam int EXP_BURSTS = int'((SCRB_MAX_ADDR + 1) / BURST_BYTES);
   localparam logic [ADDR_W-1:0] EXP_LAST = ADDR_W'(EXP_BURSTS - 1) * ADDR_W'(BURST_BYTES);

   logic                      clk = 1'b0;
   logic                      sync_rst_n;
   logic [CTL_W-1:0]          sh_cl_ctl0;
   logic [NUM_DDR-1:0]        ddr_is_ready;
   logic                      flr_assert;
   logic [NUM_DDR-1:0]        burst_ready;
   logic                      flr_done;
   logic [NUM_DDR-1:0]        burst_valid;
   logic [NUM_DDR*ADDR_W-1:0] burst_addr;
   logic [NUM_DDR-1:0]        scrb_done;
   logic [CTL_W-1:0]          cl_sh_id0;
   logic [CTL_W-1:0]          cl_sh_id1;

   integer seed = 32'h2fd6;
   int     assert_errs = 0;
   int     wait_errs = 0;
   int     err_mark = 0;
   int     test_count = 0;

   // check enables, driven with the stimulus
   logic              chk_quiet;
   logic              chk_id;
   logic              chk_seq;
   logic              chk_flr_count;
   logic [CTL_W-1:0]  exp_id0;
   logic [CTL_W-1:0]  exp_id1;

   // model of the channel under test
   logic [1:0]        mon_ch;
   logic              mon_clear;
   logic [ADDR_W-1:0] mon_addr;
   int                mon_count;
   logic              flr_clear;
   int                flr_pulses;
   logic [ADDR_W-1:0] chan_addr [NUM_DDR];
   logic              mon_valid;
   logic              mon_ready;
   logic              mon_done;
   logic [ADDR_W-1:0] mon_baddr;

   always #20 clk = ~clk;

   cl_scrub_top u_cl_scrub_top (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .sh_cl_ctl0   (sh_cl_ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done),
      .burst_valid  (burst_valid),
      .burst_addr   (burst_addr),
      .burst_ready  (burst_ready),
      .scrb_done    (scrb_done),
      .cl_sh_id0    (cl_sh_id0),
      .cl_sh_id1    (cl_sh_id1)
   );

   for (genvar i = 0; i < NUM_DDR; i++)
   begin : g_addr
      assign chan_addr[i] = burst_addr[i*ADDR_W +: ADDR_W];
   end

   assign mon_valid = burst_valid[mon_ch];
   assign mon_ready = burst_ready[mon_ch];
   assign mon_done  = scrb_done[mon_ch];
   assign mon_baddr = chan_addr[mon_ch];

   // next expected address, steps on every accepted burst
   always @(posedge clk)
   begin
      if (mon_clear)
      begin
         mon_addr  <= '0;
         mon_count <= 0;
      end
      else if (mon_valid && mon_ready)
      begin
         mon_addr  <= mon_addr + ADDR_W'(BURST_BYTES);
         mon_count <= mon_count + 1;
      end
   end

   always @(posedge clk)
   begin
      if (flr_clear)
      begin
         flr_pulses <= 0;
      end
      else if (flr_done)
      begin
         flr_pulses <= flr_pulses + 1;
      end
   end

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------

   task automatic note_value_error(input string name, input logic [ADDR_W-1:0] got,
                                   input logic [ADDR_W-1:0] exp);
      assert_errs++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
   endtask

   task automatic note_rule_error(input string msg);
      assert_errs++;
      $display("ERROR: %s at %0t", msg, $time);
   endtask

   task automatic note_timeout(input string what);
      wait_errs++;
      $display("ERROR: timed out waiting for %s at %0t", what, $time);
   endtask

   // inputs change just after the edge, ready is random every cycle
   task automatic step();
      @(posedge clk);
      #2;
      burst_ready = NUM_DDR'($random(seed));
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = assert_errs + wait_errs - err_mark;
      err_mark = assert_errs + wait_errs;
      test_count++;
      $display("%s: %0d errors", name, errs);
   endtask

   task automatic wait_done(input logic [1:0] ch, input logic level, input int limit);
      int n;
      n = 0;
      while (scrb_done[ch] != level && n < limit)
      begin
         step();
         n++;
      end
      if (scrb_done[ch] != level)
      begin
         note_timeout($sformatf("scrb_done[%0d] to become %0d", ch, level));
      end
   endtask

   // enable one channel and follow it until done
   task automatic run_scrub(input logic [1:0] ch);
      mon_ch = ch;
      mon_clear = 1'b1;
      sh_cl_ctl0 = '0;
      sh_cl_ctl0[ch] = 1'b1;
      step();
      mon_clear = 1'b0;
      chk_seq = 1'b1;
      wait_done(ch, 1'b1, 400);
      step();
      step();
      chk_seq = 1'b0;
   endtask

   // ----------------------------------------------------------------------
   // checks, sampled mid-cycle
   // ----------------------------------------------------------------------

   a_quiet_valid : assert property (@(negedge clk) disable iff (!sync_rst_n)
      chk_quiet |-> burst_valid == '0)
      else note_value_error("burst_valid", ADDR_W'(burst_valid), '0);

   a_quiet_done : assert property (@(negedge clk) disable iff (!sync_rst_n)
      chk_quiet |-> scrb_done == '0)
      else note_value_error("scrb_done", ADDR_W'(scrb_done), '0);

   a_quiet_flr : assert property (@(negedge clk) disable iff (!sync_rst_n)
      chk_quiet |-> !flr_done)
      else note_value_error("flr_done", ADDR_W'(flr_done), '0);

   a_id0 : assert property (@(negedge clk) disable iff (!sync_rst_n)
      chk_id |-> cl_sh_id0 == exp_id0)
      else note_value_error("cl_sh_id0", ADDR_W'(cl_sh_id0), ADDR_W'(exp_id0));

   a_id1 : assert property (@(negedge clk) disable iff (!sync_rst_n)
      chk_id |-> cl_sh_id1 == exp_id1)
      else note_value_error("cl_sh_id1", ADDR_W'(cl_sh_id1), ADDR_W'(exp_id1));

   a_seq_addr : assert property (@(negedge clk) disable iff (!sync_rst_n)
      chk_seq && mon_valid && mon_ready |-> mon_baddr == mon_addr)
      else note_value_error("burst_addr", mon_baddr, mon_addr);

   a_seq_hold : assert property (@(negedge clk) disable iff (!sync_rst_n)
      chk_seq && mon_valid && !mon_ready |=> mon_valid && $stable(mon_baddr))
      else note_rule_error("burst_valid or burst_addr changed while a burst waited");

   a_seq_extra : assert property (@(negedge clk) disable iff (!sync_rst_n)
      chk_seq && mon_valid |-> mon_count < EXP_BURSTS)
      else note_rule_error("burst_valid high after the last burst was accepted");

   a_seq_done : assert property (@(negedge clk) disable iff (!sync_rst_n)
      chk_seq && mon_done |-> mon_count == EXP_BURSTS)
      else note_value_error("accepted bursts", ADDR_W'(mon_count), ADDR_W'(EXP_BURSTS));

   a_flr_single : assert property (@(negedge clk) disable iff (!sync_rst_n)
      flr_done |=> !flr_done)
      else note_rule_error("flr_done high on two cycles in a row");

   a_flr_count : assert property (@(negedge clk) disable iff (!sync_rst_n)
      chk_flr_count |-> flr_pulses == 1)
      else note_value_error("flr_done pulses", ADDR_W'(flr_pulses), 64'h1);

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------

   initial
   begin
      int n;
      sync_rst_n = 1'b0;
      sh_cl_ctl0 = '0;
      ddr_is_ready = '0;
      flr_assert = 1'b0;
      burst_ready = '0;
      chk_quiet = 1'b0;
      chk_id = 1'b0;
      chk_seq = 1'b0;
      chk_flr_count = 1'b0;
      mon_ch = 2'd0;
      mon_clear = 1'b0;
      flr_clear = 1'b0;
      exp_id0 = CL_ID0;
      exp_id1 = CL_ID1;

      repeat (4) @(posedge clk);
      #2;
      sync_rst_n = 1'b1;
      chk_quiet = 1'b1;
      step();
      // ID words are valid from the first edge after reset
      chk_id = 1'b1;
      repeat (4) step();
      end_test("reset");

      // channel 1 enabled, memory not ready
      sh_cl_ctl0[1] = 1'b1;
      repeat (20) step();
      chk_quiet = 1'b0;
      ddr_is_ready = '1;
      n = 0;
      while (!burst_valid[1] && n < 8)
      begin
         step();
         n++;
      end
      if (!burst_valid[1])
      begin
         note_timeout("burst_valid[1] after ddr_is_ready");
      end
      sh_cl_ctl0 = '0;
      repeat (3) step();
      end_test("no scrub without ready");

      run_scrub(2'd0);
      sh_cl_ctl0 = '0;
      repeat (3) step();
      end_test("full scrub on channel 0");

      run_scrub(2'd2);
      chk_id = 1'b0;
      sh_cl_ctl0[DBG_EN_BIT] = 1'b1;
      sh_cl_ctl0[DBG_SEL_LSB +: DBG_SEL_W] = 3'd2;
      repeat (2) step();
      exp_id0 = EXP_LAST[CTL_W-1:0];
      exp_id1 = EXP_LAST[ADDR_W-1:CTL_W];
      chk_id = 1'b1;
      repeat (3) step();
      chk_id = 1'b0;
      // finish channels 1 and 3 so that only channel 0 reads zero
      sh_cl_ctl0[1] = 1'b1;
      sh_cl_ctl0[3] = 1'b1;
      wait_done(2'd1, 1'b1, 400);
      wait_done(2'd3, 1'b1, 400);
      sh_cl_ctl0[DBG_SEL_LSB +: DBG_SEL_W] = 3'd5;
      repeat (2) step();
      // channel 0 is disabled, so its address was cleared
      exp_id0 = '0;
      exp_id1 = '0;
      chk_id = 1'b1;
      repeat (3) step();
      chk_id = 1'b0;
      sh_cl_ctl0[DBG_EN_BIT] = 1'b0;
      repeat (2) step();
      exp_id0 = CL_ID0;
      exp_id1 = CL_ID1;
      chk_id = 1'b1;
      step();
      end_test("debug readout");

      sh_cl_ctl0[2] = 1'b0;
      wait_done(2'd2, 1'b0, 4);
      run_scrub(2'd2);
      sh_cl_ctl0 = '0;
      repeat (2) step();
      end_test("restart");

      flr_clear = 1'b1;
      flr_assert = 1'b1;
      step();
      flr_clear = 1'b0;
      flr_assert = 1'b0;
      n = 0;
      while (!flr_done && n < 3)
      begin
         step();
         n++;
      end
      if (!flr_done)
      begin
         note_timeout("flr_done after flr_assert");
      end
      repeat (4) step();
      chk_flr_count = 1'b1;
      step();
      chk_flr_count = 1'b0;
      end_test("function-level reset");

      $display("%0d tests, %0d errors", test_count, assert_errs + wait_errs);
      if (assert_errs + wait_errs == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- cl_scrub_top.sv
// Scrubber custom logic top

`timescale 1ns/1ps
`default_nettype none

module cl_scrub_top
   import scrub_pkg::*;
(
   input  wire logic                        clk,
   input  wire logic                        sync_rst_n,

   // control and status levels
   input  wire logic [CTL_W-1:0]            sh_cl_ctl0,
   input  wire logic [NUM_DDR-1:0]          ddr_is_ready,
   input  wire logic                        flr_assert,
   output logic                             flr_done,

   // per-channel burst requests
   output logic [NUM_DDR-1:0]               burst_valid,
   output logic [NUM_DDR*ADDR_W-1:0]        burst_addr,
   input  wire logic [NUM_DDR-1:0]          burst_ready,

   output logic [NUM_DDR-1:0]               scrb_done,
   output logic [CTL_W-1:0]                 cl_sh_id0,
   output logic [CTL_W-1:0]                 cl_sh_id1
);

   logic [NUM_DDR-1:0]         scrb_enable;
   logic [NUM_DDR-1:0]         ddr_ready_q;
   logic                       dbg_en;
   logic [DBG_SEL_W-1:0]       dbg_sel;
   logic [NUM_DDR*ADDR_W-1:0]  cur_addr;
   logic [NUM_DDR-1:0]         scrb_done_raw;

   // ----------------------------------------------------------------------
   // control
   // ----------------------------------------------------------------------

   scrub_ctl u_scrub_ctl (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .sh_cl_ctl0   (sh_cl_ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .scrb_enable  (scrb_enable),
      .ddr_ready_q  (ddr_ready_q),
      .dbg_en       (dbg_en),
      .dbg_sel      (dbg_sel),
      .flr_done     (flr_done)
   );

   // ----------------------------------------------------------------------
   // scrubber channels
   // ----------------------------------------------------------------------

   for (genvar i = 0; i < NUM_DDR; i++)
   begin : g_chan
      ddr_scrubber u_ddr_scrubber (
         .clk         (clk),
         .sync_rst_n  (sync_rst_n),
         .enable      (scrb_enable[i]),
         .ddr_ready   (ddr_ready_q[i]),
         .burst_valid (burst_valid[i]),
         .burst_addr  (burst_addr[i*ADDR_W +: ADDR_W]),
         .burst_ready (burst_ready[i]),
         .cur_addr    (cur_addr[i*ADDR_W +: ADDR_W]),
         .done        (scrb_done_raw[i])
      );
   end

   // ----------------------------------------------------------------------
   // status
   // ----------------------------------------------------------------------

   scrub_status u_scrub_status (
      .clk           (clk),
      .sync_rst_n    (sync_rst_n),
      .dbg_en        (dbg_en),
      .dbg_sel       (dbg_sel),
      .cur_addr      (cur_addr),
      .scrb_done_raw (scrb_done_raw),
      .cl_sh_id0     (cl_sh_id0),
      .cl_sh_id1     (cl_sh_id1),
      .scrb_done     (scrb_done)
   );

endmodule

`default_nettype wire

//--- scrub_status.sv
// Scrub status and ID readout

`timescale 1ns/1ps
`default_nettype none

module scrub_status
   import scrub_pkg::*;
(
   input  wire logic                        clk,
   input  wire logic                        sync_rst_n,

   input  wire logic                        dbg_en,
   input  wire logic [DBG_SEL_W-1:0]        dbg_sel,
   input  wire logic [NUM_DDR*ADDR_W-1:0]   cur_addr,
   input  wire logic [NUM_DDR-1:0]          scrb_done_raw,

   output logic [CTL_W-1:0]                 cl_sh_id0,
   output logic [CTL_W-1:0]                 cl_sh_id1,
   output logic [NUM_DDR-1:0]               scrb_done
);

   logic [ADDR_W-1:0] sel_addr;

   // ----------------------------------------------------------------------
   // debug channel select
   // ----------------------------------------------------------------------

   // out-of-range selects fall back to channel 0
   always_comb
   begin
      sel_addr = cur_addr[0 +: ADDR_W];
      for (int i = 1; i < NUM_DDR; i++)
      begin
         if (int'(dbg_sel) == i)
         begin
            sel_addr = cur_addr[i*ADDR_W +: ADDR_W];
         end
      end
   end

   // ID words, low half on id0 and high half on id1
   always_ff @(posedge clk)
   begin
      if (dbg_en)
      begin
         cl_sh_id0 <= sel_addr[CTL_W-1:0];
         cl_sh_id1 <= sel_addr[ADDR_W-1:CTL_W];
      end
      else
      begin
         cl_sh_id0 <= CL_ID0;
         cl_sh_id1 <= CL_ID1;
      end
   end

   // ----------------------------------------------------------------------
   // done flags
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         scrb_done <= '0;
      end
      else
      begin
         scrb_done <= scrb_done_raw;
      end
   end

endmodule

`default_nettype wire

//--- ddr_scrubber.sv
// DDR scrubber channel

`timescale 1ns/1ps
`default_nettype none

module ddr_scrubber
   import scrub_pkg::*;
(
   input  wire logic                clk,
   input  wire logic                sync_rst_n,

   input  wire logic                enable,
   input  wire logic                ddr_ready,

   // burst request toward the memory
   output logic                     burst_valid,
   output logic [ADDR_W-1:0]        burst_addr,
   input  wire logic                burst_ready,

   // status
   output logic [ADDR_W-1:0]        cur_addr,
   output logic                     done
);

   scrub_state_e      state;
   logic [ADDR_W-1:0] addr;
   logic [ADDR_W-1:0] next_addr;
   logic              last_burst;
   logic              accept;

   assign accept    = burst_valid && burst_ready;
   assign next_addr = addr + ADDR_W'(BURST_BYTES);

   // next step would run past the end of the range
   assign last_burst = next_addr > SCRB_MAX_ADDR;

   // ----------------------------------------------------------------------
   // scrub FSM and address counter
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state <= SCRB_IDLE;
         addr  <= '0;
      end
      else if (!enable)
      begin
         // dropping the enable aborts and rewinds from any state
         state <= SCRB_IDLE;
         addr  <= '0;
      end
      else
      begin
         case (state)
            SCRB_IDLE:
            begin
               if (ddr_ready)
               begin
                  state <= SCRB_ISSUE;
                  addr  <= '0;
               end
            end
            SCRB_ISSUE:
            begin
               if (accept)
               begin
                  if (last_burst)
                  begin
                     state <= SCRB_DONE;
                  end
                  else
                  begin
                     addr <= next_addr;
                  end
               end
            end
            SCRB_DONE:
            begin
               // park here, address keeps the final burst
               state <= SCRB_DONE;
            end
            default:
            begin
               state <= SCRB_IDLE;
            end
         endcase
      end
   end

   assign burst_valid = (state == SCRB_ISSUE);
   assign burst_addr  = addr;
   assign cur_addr    = addr;
   assign done        = (state == SCRB_DONE);

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------

   // a stalled burst keeps its address
   a_addr_stable : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      (burst_valid && !burst_ready && enable) |=> $stable(burst_addr)
   );

   a_done_no_valid : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      !(done && burst_valid)
   );

   a_addr_aligned : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      (burst_addr % ADDR_W'(BURST_BYTES)) == '0
   );

endmodule

`default_nettype wire

//--- scrub_ctl.sv
// Scrub control register

`timescale 1ns/1ps
`default_nettype none

module scrub_ctl
   import scrub_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 sync_rst_n,

   input  wire logic [CTL_W-1:0]     sh_cl_ctl0,
   input  wire logic [NUM_DDR-1:0]   ddr_is_ready,
   input  wire logic                 flr_assert,

   output logic [NUM_DDR-1:0]        scrb_enable,
   output logic [NUM_DDR-1:0]        ddr_ready_q,
   output logic                      dbg_en,
   output logic [DBG_SEL_W-1:0]      dbg_sel,
   output logic                      flr_done
);

   logic [CTL_W-1:0] ctl_q;
   logic             flr_assert_q;

   // ----------------------------------------------------------------------
   // control word and ready levels
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl_q       <= '0;
         ddr_ready_q <= '0;
      end
      else
      begin
         ctl_q       <= sh_cl_ctl0;
         ddr_ready_q <= ddr_is_ready;
      end
   end

   // one enable bit per channel, straight map
   assign scrb_enable = ctl_q[NUM_DDR-1:0];

   // debug readout fields in the top nibble
   assign dbg_en  = ctl_q[DBG_EN_BIT];
   assign dbg_sel = ctl_q[DBG_SEL_LSB +: DBG_SEL_W];

   // ----------------------------------------------------------------------
   // function-level reset response
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         // single-cycle answer, suppressed right after a pulse
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

   // done must drop again after one cycle
   a_flr_done_single : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      flr_done |=> !flr_done
   );

endmodule

`default_nettype wire

//--- scrub_pkg.sv
// DDR scrubber shared definitions

`default_nettype none

package scrub_pkg;

   // ----------------------------------------------------------------------
   // sizes
   // ----------------------------------------------------------------------

   // scrubber channels, one per DDR port
   localparam int NUM_DDR = 4;

   // byte address width of a scrub burst
   localparam int ADDR_W = 64;

   // control word and ID word width
   localparam int CTL_W = 32;

   // ----------------------------------------------------------------------
   // scrub range and burst shape
   // ----------------------------------------------------------------------

   // 8 KiB per channel, enough to walk the whole sequence quickly
   localparam logic [ADDR_W-1:0] SCRB_MAX_ADDR = 64'h1FFF;

   // 16 beats of 64 bytes each
   localparam int BURST_LEN_MINUS1 = 15;
   localparam int BEAT_BYTES = 64;

   // address step from one burst to the next
   localparam int BURST_BYTES = (BURST_LEN_MINUS1 + 1) * BEAT_BYTES;

   // ----------------------------------------------------------------------
   // control word fields
   // ----------------------------------------------------------------------

   // bit i of the word enables channel i
   localparam int DBG_EN_BIT = 31;
   localparam int DBG_SEL_LSB = 28;
   localparam int DBG_SEL_W = 3;

   // fixed ID words shown while debug readout is off
   localparam logic [CTL_W-1:0] CL_ID0 = 32'h1D51_FEDD;
   localparam logic [CTL_W-1:0] CL_ID1 = 32'h1D50_6000;

   // scrubber FSM states
   typedef enum logic [1:0]
   {
      SCRB_IDLE  = 2'd0,
      SCRB_ISSUE = 2'd1,
      SCRB_DONE  = 2'd2
   } scrub_state_e;

endpackage

`default_nettype wire
